// File: rtl/biu_pkg.sv
`default_nettype none

package biu_pkg;

    // Bytes in one BIU data word
    localparam int BIU_DATA_BYTES = 4;

    // Request kind
    typedef enum logic [1:0] {
        BIU_FUNC_READ  = 2'b00,
        BIU_FUNC_WRITE = 2'b01,
        BIU_FUNC_RMW   = 2'b10
    } biu_func_t;

    // Transfer length in bytes
    typedef enum logic [1:0] {
        BIU_LEN_1B = 2'b00,
        BIU_LEN_2B = 2'b01,
        BIU_LEN_4B = 2'b10
    } biu_len_t;

    // Byte i of the word holds address plus i
    typedef logic [BIU_DATA_BYTES*8-1:0] biu_data_t;
    typedef logic [BIU_DATA_BYTES-1:0]   biu_sel_t;
    typedef logic [31:0]                 biu_addr_t;

endpackage

`default_nettype wire

// File: rtl/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // Cycle type identifiers
    typedef logic [2:0] wb_cti_t;
    localparam wb_cti_t WB_CTI_CLASSIC = 3'b000;
    localparam wb_cti_t WB_CTI_INCR    = 3'b010;
    localparam wb_cti_t WB_CTI_END     = 3'b111;

    // Burst type with only linear bursts issued
    typedef logic [1:0] wb_bte_t;
    localparam wb_bte_t WB_BTE_LINEAR = 2'b00;

    // 16-bit data port with byte granularity
    localparam int WB_DATA_BYTES = 2;
    localparam int WB_DATA_W     = WB_DATA_BYTES * 8;
    typedef logic [WB_DATA_W-1:0]     wb_data_t;
    typedef logic [WB_DATA_BYTES-1:0] wb_sel_t;
    typedef logic [31:0]              wb_addr_t;

    // SRAM size in halfwords
    localparam int WB_SRAM_WORDS = 256;
    localparam int WB_SRAM_AW    = $clog2(WB_SRAM_WORDS);

endpackage

`default_nettype wire

// File: rtl/biu_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module biu_arbiter (
    input  wire logic               i_wb_clk,
    input  wire logic               i_arst_n,

    // Client a
    input  wire logic               i_a_en,
    input  wire biu_pkg::biu_func_t i_a_func,
    input  wire biu_pkg::biu_len_t  i_a_len,
    input  wire biu_pkg::biu_sel_t  i_a_sel,
    input  wire biu_pkg::biu_addr_t i_a_addr,
    input  wire biu_pkg::biu_data_t i_a_data,
    output logic                    o_a_done,
    output biu_pkg::biu_data_t      o_a_data,

    // Client b
    input  wire logic               i_b_en,
    input  wire biu_pkg::biu_func_t i_b_func,
    input  wire biu_pkg::biu_len_t  i_b_len,
    input  wire biu_pkg::biu_sel_t  i_b_sel,
    input  wire biu_pkg::biu_addr_t i_b_addr,
    input  wire biu_pkg::biu_data_t i_b_data,
    output logic                    o_b_done,
    output biu_pkg::biu_data_t      o_b_data,

    // Controller side
    output logic                    o_biu_en,
    output biu_pkg::biu_func_t      o_biu_func,
    output biu_pkg::biu_len_t       o_biu_len,
    output biu_pkg::biu_sel_t       o_biu_sel,
    output biu_pkg::biu_addr_t      o_biu_addr,
    output biu_pkg::biu_data_t      o_biu_data,
    input  wire logic               i_biu_done,
    input  wire biu_pkg::biu_data_t i_biu_data
);

    logic busy_r;
    logic grant_b_r;
    logic last_b_r;
    logic pick_b;
    logic start;

    // Client b wins if alone, or if both wait and a was served last
    assign pick_b = i_b_en & (~i_a_en | ~last_b_r);
    assign start  = ~busy_r & (i_a_en | i_b_en);

    always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_r    <= 1'b0;
            grant_b_r <= 1'b0;
            last_b_r  <= 1'b0;
            o_biu_en  <= 1'b0;
        end else begin
            o_biu_en <= start;
            if (start) begin
                busy_r    <= 1'b1;
                grant_b_r <= pick_b;
            end else if (busy_r && i_biu_done) begin
                busy_r   <= 1'b0;
                last_b_r <= grant_b_r;
            end
        end
    end

    // Request fields stay latched for the whole grant
    always_ff @(posedge i_wb_clk) begin
        if (start) begin
            if (pick_b) begin
                o_biu_func <= i_b_func;
                o_biu_len  <= i_b_len;
                o_biu_sel  <= i_b_sel;
                o_biu_addr <= i_b_addr;
                o_biu_data <= i_b_data;
            end else begin
                o_biu_func <= i_a_func;
                o_biu_len  <= i_a_len;
                o_biu_sel  <= i_a_sel;
                o_biu_addr <= i_a_addr;
                o_biu_data <= i_a_data;
            end
        end
    end

    // Done and read data go only to the granted client
    assign o_a_done = busy_r & ~grant_b_r & i_biu_done;
    assign o_b_done = busy_r & grant_b_r & i_biu_done;
    assign o_a_data = (busy_r && !grant_b_r) ? i_biu_data : '0;
    assign o_b_data = (busy_r && grant_b_r) ? i_biu_data : '0;

endmodule

`default_nettype wire

// File: rtl/biu_wb_controller.sv
`timescale 1ns/1ns
`default_nettype none

module biu_wb_controller (
    input  wire logic               i_wb_clk,
    input  wire logic               i_arst_n,

    // Request side
    input  wire logic               i_biu_en,
    input  wire biu_pkg::biu_func_t i_biu_func,
    input  wire biu_pkg::biu_len_t  i_biu_len,
    input  wire biu_pkg::biu_sel_t  i_biu_sel,
    input  wire biu_pkg::biu_addr_t i_biu_addr,
    input  wire biu_pkg::biu_data_t i_biu_data,
    output logic                    o_biu_done,
    output biu_pkg::biu_data_t      o_biu_data,

    // Wishbone master
    input  wire logic               i_wb_ack,
    input  wire wb_pkg::wb_data_t   i_wb_data,
    output logic                    o_wb_cyc,
    output logic                    o_wb_stb,
    output logic                    o_wb_we,
    output wb_pkg::wb_cti_t         o_wb_cti,
    output wb_pkg::wb_bte_t         o_wb_bte,
    output wb_pkg::wb_sel_t         o_wb_sel,
    output wb_pkg::wb_addr_t        o_wb_addr,
    output wb_pkg::wb_data_t        o_wb_data
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEND_REQ,
        ST_RMW_READ,
        ST_RMW_MODIFY,
        ST_RMW_WRITE,
        ST_DONE
    } state_t;

    state_t             state_r;
    state_t             state_next;
    // Remaining beats and current halfword lane of the BIU word
    logic [1:0]         cnt_r;
    logic [1:0]         cnt_next;
    logic               idx_r;
    logic               idx_next;
    logic [1:0]         init_cnt;
    logic               done_next;
    biu_pkg::biu_data_t rdata_next;
    logic               cyc_next;
    logic               stb_next;
    logic               we_next;
    wb_pkg::wb_cti_t    cti_next;
    wb_pkg::wb_sel_t    sel_next;
    wb_pkg::wb_addr_t   addr_next;
    wb_pkg::wb_data_t   wdata_next;
    wb_pkg::wb_sel_t    lane_sel;
    wb_pkg::wb_data_t   lane_new;
    wb_pkg::wb_data_t   lane_old;
    wb_pkg::wb_data_t   rmw_data;

    // Short transfers still take one full beat
    always_comb begin
        if (i_biu_len == biu_pkg::BIU_LEN_4B) begin
            init_cnt = 2'(biu_pkg::BIU_DATA_BYTES / wb_pkg::WB_DATA_BYTES);
        end else begin
            init_cnt = 2'd1;
        end
    end

    // Merge selected bytes of the write data over the halfword just read
    always_comb begin
        lane_sel = i_biu_sel[idx_r*wb_pkg::WB_DATA_BYTES +: wb_pkg::WB_DATA_BYTES];
        lane_new = i_biu_data[idx_r*wb_pkg::WB_DATA_W +: wb_pkg::WB_DATA_W];
        lane_old = o_biu_data[idx_r*wb_pkg::WB_DATA_W +: wb_pkg::WB_DATA_W];
        for (int b = 0; b < wb_pkg::WB_DATA_BYTES; b++) begin
            rmw_data[b*8 +: 8] = lane_sel[b] ? lane_new[b*8 +: 8] : lane_old[b*8 +: 8];
        end
    end

    always_comb begin
        state_next = state_r;
        cnt_next   = cnt_r;
        idx_next   = idx_r;
        done_next  = 1'b0;
        rdata_next = o_biu_data;
        cyc_next   = o_wb_cyc;
        stb_next   = o_wb_stb;
        we_next    = o_wb_we;
        cti_next   = o_wb_cti;
        sel_next   = o_wb_sel;
        addr_next  = o_wb_addr;
        wdata_next = o_wb_data;

        case (state_r)
            ST_IDLE: begin
                cnt_next   = init_cnt;
                idx_next   = 1'b0;
                rdata_next = '0;
                cyc_next   = i_biu_en;
                stb_next   = i_biu_en;
                we_next    = (i_biu_func == biu_pkg::BIU_FUNC_WRITE);
                addr_next  = i_biu_addr;
                wdata_next = i_biu_data[wb_pkg::WB_DATA_W-1:0];
                if (i_biu_func == biu_pkg::BIU_FUNC_RMW) begin
                    // Whole halfword is read and written back
                    cti_next = wb_pkg::WB_CTI_CLASSIC;
                    sel_next = '1;
                end else begin
                    cti_next = (init_cnt == 2'd1) ? wb_pkg::WB_CTI_END : wb_pkg::WB_CTI_INCR;
                    sel_next = i_biu_sel[wb_pkg::WB_DATA_BYTES-1:0];
                end
                if (i_biu_en) begin
                    if (i_biu_func == biu_pkg::BIU_FUNC_RMW) begin
                        state_next = ST_RMW_READ;
                    end else begin
                        state_next = ST_SEND_REQ;
                    end
                end
            end
            ST_SEND_REQ: begin
                if (i_wb_ack) begin
                    cnt_next  = cnt_r - 2'd1;
                    idx_next  = idx_r + 1'b1;
                    addr_next = o_wb_addr + wb_pkg::wb_addr_t'(wb_pkg::WB_DATA_BYTES);
                    if (!o_wb_we) begin
                        rdata_next[idx_r*wb_pkg::WB_DATA_W +: wb_pkg::WB_DATA_W] = i_wb_data;
                    end
                    sel_next   = i_biu_sel[idx_next*wb_pkg::WB_DATA_BYTES +:
                                           wb_pkg::WB_DATA_BYTES];
                    wdata_next = i_biu_data[idx_next*wb_pkg::WB_DATA_W +: wb_pkg::WB_DATA_W];
                    // Tag the final beat of the burst
                    if (cnt_next == 2'd1) begin
                        cti_next = wb_pkg::WB_CTI_END;
                    end
                    if (cnt_next == 2'd0) begin
                        cyc_next   = 1'b0;
                        stb_next   = 1'b0;
                        we_next    = 1'b0;
                        done_next  = 1'b1;
                        state_next = ST_DONE;
                    end
                end
            end
            ST_RMW_READ: begin
                if (i_wb_ack) begin
                    stb_next   = 1'b0;
                    rdata_next[idx_r*wb_pkg::WB_DATA_W +: wb_pkg::WB_DATA_W] = i_wb_data;
                    state_next = ST_RMW_MODIFY;
                end
            end
            ST_RMW_MODIFY: begin
                stb_next   = 1'b1;
                we_next    = 1'b1;
                wdata_next = rmw_data;
                state_next = ST_RMW_WRITE;
            end
            ST_RMW_WRITE: begin
                if (i_wb_ack) begin
                    cnt_next  = cnt_r - 2'd1;
                    idx_next  = idx_r + 1'b1;
                    addr_next = o_wb_addr + wb_pkg::wb_addr_t'(wb_pkg::WB_DATA_BYTES);
                    we_next   = 1'b0;
                    if (cnt_next == 2'd0) begin
                        cyc_next   = 1'b0;
                        stb_next   = 1'b0;
                        done_next  = 1'b1;
                        state_next = ST_DONE;
                    end else begin
                        // Strobe stays up for the next read beat
                        state_next = ST_RMW_READ;
                    end
                end
            end
            ST_DONE: begin
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_r    <= ST_IDLE;
            cnt_r      <= 2'd0;
            idx_r      <= 1'b0;
            o_biu_done <= 1'b0;
            o_wb_cyc   <= 1'b0;
            o_wb_stb   <= 1'b0;
            o_wb_we    <= 1'b0;
        end else begin
            state_r    <= state_next;
            cnt_r      <= cnt_next;
            idx_r      <= idx_next;
            o_biu_done <= done_next;
            o_wb_cyc   <= cyc_next;
            o_wb_stb   <= stb_next;
            o_wb_we    <= we_next;
        end
    end

    always_ff @(posedge i_wb_clk) begin
        o_biu_data <= rdata_next;
        o_wb_cti   <= cti_next;
        o_wb_sel   <= sel_next;
        o_wb_addr  <= addr_next;
        o_wb_data  <= wdata_next;
    end

    assign o_wb_bte = wb_pkg::WB_BTE_LINEAR;

endmodule

`default_nettype wire

// File: rtl/wb_sram.sv
`timescale 1ns/1ns
`default_nettype none

module wb_sram (
    input  wire logic             i_wb_clk,
    input  wire logic             i_arst_n,
    input  wire logic             i_wb_cyc,
    input  wire logic             i_wb_stb,
    input  wire logic             i_wb_we,
    input  wire wb_pkg::wb_sel_t  i_wb_sel,
    input  wire wb_pkg::wb_addr_t i_wb_addr,
    input  wire wb_pkg::wb_data_t i_wb_data,
    output logic                  o_wb_ack,
    output wb_pkg::wb_data_t      o_wb_data
);

    wb_pkg::wb_data_t                mem [wb_pkg::WB_SRAM_WORDS];
    logic [wb_pkg::WB_SRAM_AW-1:0]   word_idx;
    logic                            access;

    // Halfword index from the byte address
    assign word_idx = i_wb_addr[wb_pkg::WB_SRAM_AW:1];

    // A beat is served once, in the cycle before its ack
    assign access = i_wb_cyc & i_wb_stb & ~o_wb_ack;

    always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb_ack <= 1'b0;
            for (int i = 0; i < wb_pkg::WB_SRAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            o_wb_ack <= access;
            if (access && i_wb_we) begin
                for (int b = 0; b < wb_pkg::WB_DATA_BYTES; b++) begin
                    if (i_wb_sel[b]) begin
                        mem[word_idx][b*8 +: 8] <= i_wb_data[b*8 +: 8];
                    end
                end
            end
        end
    end

    // Read data lines up with ack
    always_ff @(posedge i_wb_clk) begin
        if (access) begin
            o_wb_data <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

// File: rtl/biu_wb_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module biu_wb_subsys (
    input  wire logic               i_wb_clk,
    input  wire logic               i_arst_n,

    // Client a
    input  wire logic               i_a_en,
    input  wire biu_pkg::biu_func_t i_a_func,
    input  wire biu_pkg::biu_len_t  i_a_len,
    input  wire biu_pkg::biu_sel_t  i_a_sel,
    input  wire biu_pkg::biu_addr_t i_a_addr,
    input  wire biu_pkg::biu_data_t i_a_data,
    output logic                    o_a_done,
    output biu_pkg::biu_data_t      o_a_data,

    // Client b
    input  wire logic               i_b_en,
    input  wire biu_pkg::biu_func_t i_b_func,
    input  wire biu_pkg::biu_len_t  i_b_len,
    input  wire biu_pkg::biu_sel_t  i_b_sel,
    input  wire biu_pkg::biu_addr_t i_b_addr,
    input  wire biu_pkg::biu_data_t i_b_data,
    output logic                    o_b_done,
    output biu_pkg::biu_data_t      o_b_data
);

    // Arbiter to controller
    logic               biu_en;
    biu_pkg::biu_func_t biu_func;
    biu_pkg::biu_len_t  biu_len;
    biu_pkg::biu_sel_t  biu_sel;
    biu_pkg::biu_addr_t biu_addr;
    biu_pkg::biu_data_t biu_wdata;
    logic               biu_done;
    biu_pkg::biu_data_t biu_rdata;

    // Wishbone bus
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    wb_pkg::wb_cti_t    wb_cti;
    wb_pkg::wb_bte_t    wb_bte;
    wb_pkg::wb_sel_t    wb_sel;
    wb_pkg::wb_addr_t   wb_addr;
    wb_pkg::wb_data_t   wb_wdata;
    logic               wb_ack;
    wb_pkg::wb_data_t   wb_rdata;

    biu_arbiter i_biu_arbiter (
        .i_wb_clk   (i_wb_clk),
        .i_arst_n   (i_arst_n),
        .i_a_en     (i_a_en),
        .i_a_func   (i_a_func),
        .i_a_len    (i_a_len),
        .i_a_sel    (i_a_sel),
        .i_a_addr   (i_a_addr),
        .i_a_data   (i_a_data),
        .o_a_done   (o_a_done),
        .o_a_data   (o_a_data),
        .i_b_en     (i_b_en),
        .i_b_func   (i_b_func),
        .i_b_len    (i_b_len),
        .i_b_sel    (i_b_sel),
        .i_b_addr   (i_b_addr),
        .i_b_data   (i_b_data),
        .o_b_done   (o_b_done),
        .o_b_data   (o_b_data),
        .o_biu_en   (biu_en),
        .o_biu_func (biu_func),
        .o_biu_len  (biu_len),
        .o_biu_sel  (biu_sel),
        .o_biu_addr (biu_addr),
        .o_biu_data (biu_wdata),
        .i_biu_done (biu_done),
        .i_biu_data (biu_rdata)
    );

    biu_wb_controller i_biu_wb_controller (
        .i_wb_clk   (i_wb_clk),
        .i_arst_n   (i_arst_n),
        .i_biu_en   (biu_en),
        .i_biu_func (biu_func),
        .i_biu_len  (biu_len),
        .i_biu_sel  (biu_sel),
        .i_biu_addr (biu_addr),
        .i_biu_data (biu_wdata),
        .o_biu_done (biu_done),
        .o_biu_data (biu_rdata),
        .i_wb_ack   (wb_ack),
        .i_wb_data  (wb_rdata),
        .o_wb_cyc   (wb_cyc),
        .o_wb_stb   (wb_stb),
        .o_wb_we    (wb_we),
        .o_wb_cti   (wb_cti),
        .o_wb_bte   (wb_bte),
        .o_wb_sel   (wb_sel),
        .o_wb_addr  (wb_addr),
        .o_wb_data  (wb_wdata)
    );

    // The SRAM has no burst logic and takes no cti or bte
    wb_sram i_wb_sram (
        .i_wb_clk  (i_wb_clk),
        .i_arst_n  (i_arst_n),
        .i_wb_cyc  (wb_cyc),
        .i_wb_stb  (wb_stb),
        .i_wb_we   (wb_we),
        .i_wb_sel  (wb_sel),
        .i_wb_addr (wb_addr),
        .i_wb_data (wb_wdata),
        .o_wb_ack  (wb_ack),
        .o_wb_data (wb_rdata)
    );

endmodule

`default_nettype wire

// File: dv/tb_biu_wb_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_biu_wb_subsys;

    localparam int NUM_REQS        = 200;
    localparam int REQS_PER_CLIENT = NUM_REQS / 2;
    localparam int RESET_CYCLES    = 10;
    localparam int TIMEOUT_CYCLES  = NUM_REQS * 16;
    // Longest wait is the other client's request and then our own
    localparam int MAX_WAIT        = 32;

    typedef logic [15:0]                   count_t;
    typedef logic [wb_pkg::WB_SRAM_AW-1:0] word_idx_t;

    logic               clk;
    logic               arst_n;
    logic               a_en;
    biu_pkg::biu_func_t a_func;
    biu_pkg::biu_len_t  a_len;
    biu_pkg::biu_sel_t  a_sel;
    biu_pkg::biu_addr_t a_addr;
    biu_pkg::biu_data_t a_wdata;
    logic               a_done;
    biu_pkg::biu_data_t a_rdata;
    logic               b_en;
    biu_pkg::biu_func_t b_func;
    biu_pkg::biu_len_t  b_len;
    biu_pkg::biu_sel_t  b_sel;
    biu_pkg::biu_addr_t b_addr;
    biu_pkg::biu_data_t b_wdata;
    logic               b_done;
    biu_pkg::biu_data_t b_rdata;

    // Per-client request state with client a at index 0
    logic               pend [2];
    logic               follow [2];
    int                 issued [2];
    int                 dones [2];
    int                 wait_cyc [2];
    biu_pkg::biu_func_t req_func [2];
    biu_pkg::biu_len_t  req_len [2];
    biu_pkg::biu_sel_t  req_sel [2];
    biu_pkg::biu_addr_t req_addr [2];
    biu_pkg::biu_data_t req_data [2];

    wb_pkg::wb_data_t   model_mem [wb_pkg::WB_SRAM_WORDS];
    logic [31:0]        lfsr;
    int                 data_errors;
    int                 count_errors;
    int                 proto_errors;
    int                 cycle;
    int                 timeout_cnt;
    // Grant expected from the arbitration rule
    logic               bus_free;
    // Minus one when either client may win
    int                 grant_to;
    int                 grant_cycle;
    int                 last_served;

    biu_wb_subsys i_biu_wb_subsys (
        .i_wb_clk (clk),
        .i_arst_n (arst_n),
        .i_a_en   (a_en),
        .i_a_func (a_func),
        .i_a_len  (a_len),
        .i_a_sel  (a_sel),
        .i_a_addr (a_addr),
        .i_a_data (a_wdata),
        .o_a_done (a_done),
        .o_a_data (a_rdata),
        .i_b_en   (b_en),
        .i_b_func (b_func),
        .i_b_len  (b_len),
        .i_b_sel  (b_sel),
        .i_b_addr (b_addr),
        .i_b_data (b_wdata),
        .o_b_done (b_done),
        .o_b_data (b_rdata)
    );

    always #4 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // Length in bytes over the port width and at least one beat
    function automatic int beat_count(input biu_pkg::biu_len_t l);
        int bytes;
        case (l)
            biu_pkg::BIU_LEN_1B: bytes = 1;
            biu_pkg::BIU_LEN_2B: bytes = 2;
            default:             bytes = 4;
        endcase
        if (bytes < wb_pkg::WB_DATA_BYTES) begin
            return 1;
        end
        return bytes / wb_pkg::WB_DATA_BYTES;
    endfunction

    // Grant cycle, biu_en cycle, then the beats up to the done cycle
    function automatic count_t expected_latency(input biu_pkg::biu_func_t f,
                                                input biu_pkg::biu_len_t l);
        int per_beat;
        per_beat = (f == biu_pkg::BIU_FUNC_RMW) ? 5 : 2;
        return count_t'(2 + per_beat * beat_count(l));
    endfunction

    function automatic biu_pkg::biu_data_t model_read(input biu_pkg::biu_addr_t addr,
                                                      input biu_pkg::biu_len_t l);
        biu_pkg::biu_data_t d;
        word_idx_t          idx;
        d = '0;
        for (int k = 0; k < beat_count(l); k++) begin
            idx = addr[wb_pkg::WB_SRAM_AW:1] + word_idx_t'(k);
            d[k*16 +: 16] = model_mem[idx];
        end
        return d;
    endfunction

    task automatic model_write(input int c);
        word_idx_t idx;
        for (int k = 0; k < beat_count(req_len[c]); k++) begin
            idx = req_addr[c][wb_pkg::WB_SRAM_AW:1] + word_idx_t'(k);
            for (int b = 0; b < 2; b++) begin
                if (req_sel[c][2*k+b]) begin
                    model_mem[idx][b*8 +: 8] = req_data[c][(2*k+b)*8 +: 8];
                end
            end
        end
    endtask

    task automatic check_data(input string name, input biu_pkg::biu_data_t exp,
                              input biu_pkg::biu_data_t act);
        if (act !== exp) begin
            data_errors++;
            $display("ERROR %0t ns %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (act !== exp) begin
            count_errors++;
            $display("ERROR %0t ns %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic protocol_error(input string msg);
        proto_errors++;
        $display("Protocol failure at %0t ns: %s", $time, msg);
    endtask

    task automatic drive_client(input int c, input logic en);
        if (c == 1) begin
            b_en    <= en;
            b_func  <= req_func[1];
            b_len   <= req_len[1];
            b_sel   <= req_sel[1];
            b_addr  <= req_addr[1];
            b_wdata <= req_data[1];
        end else begin
            a_en    <= en;
            a_func  <= req_func[0];
            a_len   <= req_len[0];
            a_sel   <= req_sel[0];
            a_addr  <= req_addr[0];
            a_wdata <= req_data[0];
        end
    endtask

    task automatic new_request(input int c);
        logic [1:0] kind;
        word_idx_t  idx;
        if (follow[c] && rand_bits(1) != 0) begin
            // Read back what the last write or RMW left
            req_func[c] = biu_pkg::BIU_FUNC_READ;
        end else begin
            kind = 2'(rand_bits(2));
            case (kind)
                2'd1:    req_func[c] = biu_pkg::BIU_FUNC_WRITE;
                2'd2:    req_func[c] = biu_pkg::BIU_FUNC_RMW;
                default: req_func[c] = biu_pkg::BIU_FUNC_READ;
            endcase
            kind = 2'(rand_bits(2));
            case (kind)
                2'd0:    req_len[c] = biu_pkg::BIU_LEN_1B;
                2'd1:    req_len[c] = biu_pkg::BIU_LEN_2B;
                default: req_len[c] = biu_pkg::BIU_LEN_4B;
            endcase
            // Mostly a small shared window so clients hit the same words
            if (rand_bits(2) != 0) begin
                idx = word_idx_t'(rand_bits(4));
            end else begin
                idx = word_idx_t'(rand_bits(wb_pkg::WB_SRAM_AW));
            end
            req_addr[c] = biu_pkg::biu_addr_t'({idx, 1'b0});
            req_sel[c]  = biu_pkg::biu_sel_t'(rand_bits(4));
            req_data[c] = rand_bits(32);
        end
        follow[c]   = (req_func[c] != biu_pkg::BIU_FUNC_READ);
        pend[c]     = 1'b1;
        wait_cyc[c] = 0;
        issued[c]++;
        drive_client(c, 1'b1);
    endtask

    task automatic handle_done(input int c);
        biu_pkg::biu_data_t exp;
        biu_pkg::biu_data_t act;
        if (!pend[c]) begin
            protocol_error($sformatf("client %0d saw done with no pending request", c));
        end else begin
            act = (c == 1) ? b_rdata : a_rdata;
            if (req_func[c] != biu_pkg::BIU_FUNC_WRITE) begin
                exp = model_read(req_addr[c], req_len[c]);
                check_data($sformatf("o_%s_data", (c == 1) ? "b" : "a"), exp, act);
            end
            if (req_func[c] != biu_pkg::BIU_FUNC_READ) begin
                model_write(c);
            end
            if (grant_to >= 0 && grant_to != c) begin
                protocol_error($sformatf("done went to client %0d, grant was for %0d",
                                         c, grant_to));
            end
            check_count("done latency", expected_latency(req_func[c], req_len[c]),
                        count_t'(cycle - grant_cycle));
            last_served = c;
            pend[c] = 1'b0;
            drive_client(c, 1'b0);
        end
    endtask

    // Work on the values of the cycle that just ended
    task automatic step_cycle();
        logic done_c;
        cycle++;
        if (a_done && b_done) begin
            protocol_error("both clients saw done in the same cycle");
        end
        for (int c = 0; c < 2; c++) begin
            done_c = (c == 1) ? b_done : a_done;
            if (done_c) begin
                dones[c]++;
                handle_done(c);
            end else if (pend[c]) begin
                wait_cyc[c]++;
                if (wait_cyc[c] == MAX_WAIT) begin
                    protocol_error($sformatf("client %0d starved for %0d cycles", c, MAX_WAIT));
                end
            end else if (issued[c] < REQS_PER_CLIENT && cycle > 3 && rand_bits(2) != 0) begin
                new_request(c);
            end
        end
        if (a_done || b_done) begin
            bus_free = 1'b1;
        end else if (bus_free && (a_en || b_en)) begin
            bus_free    = 1'b0;
            grant_cycle = cycle;
            if (a_en && b_en) begin
                grant_to = (last_served < 0) ? -1 : 1 - last_served;
            end else begin
                grant_to = a_en ? 0 : 1;
            end
        end
    endtask

    always @(posedge clk) begin
        timeout_cnt <= timeout_cnt + 1;
        if (timeout_cnt == RESET_CYCLES + TIMEOUT_CYCLES) begin
            $display("Timeout: requests still open after %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        lfsr         = 32'hfe1a_9e00;
        timeout_cnt  = 0;
        cycle        = 0;
        data_errors  = 0;
        count_errors = 0;
        proto_errors = 0;
        bus_free     = 1'b1;
        grant_to     = -1;
        grant_cycle  = 0;
        last_served  = -1;
        for (int c = 0; c < 2; c++) begin
            pend[c]     = 1'b0;
            follow[c]   = 1'b0;
            issued[c]   = 0;
            dones[c]    = 0;
            wait_cyc[c] = 0;
            req_func[c] = biu_pkg::BIU_FUNC_READ;
            req_len[c]  = biu_pkg::BIU_LEN_1B;
            req_sel[c]  = '0;
            req_addr[c] = '0;
            req_data[c] = '0;
        end
        for (int i = 0; i < wb_pkg::WB_SRAM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        a_en    = 1'b0;
        a_func  = biu_pkg::BIU_FUNC_READ;
        a_len   = biu_pkg::BIU_LEN_1B;
        a_sel   = '0;
        a_addr  = '0;
        a_wdata = '0;
        b_en    = 1'b0;
        b_func  = biu_pkg::BIU_FUNC_READ;
        b_len   = biu_pkg::BIU_LEN_1B;
        b_sel   = '0;
        b_addr  = '0;
        b_wdata = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        while (dones[0] + dones[1] < NUM_REQS) begin
            @(posedge clk);
            step_cycle();
        end
        // Quiet tail where any stray done is flagged
        repeat (8) begin
            @(posedge clk);
            step_cycle();
        end

        check_count("client a done count", count_t'(issued[0]), count_t'(dones[0]));
        check_count("client b done count", count_t'(issued[1]), count_t'(dones[1]));
        $display("Errors: data %0d, count %0d, protocol %0d",
                 data_errors, count_errors, proto_errors);
        if (data_errors + count_errors + proto_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
rtl/biu_pkg.sv
rtl/wb_pkg.sv
rtl/biu_arbiter.sv
rtl/biu_wb_controller.sv
rtl/wb_sram.sv
rtl/biu_wb_subsys.sv
dv/tb_biu_wb_subsys.sv
